//--- src/mem_pkg.sv
// Shared definitions for the memory controller
// Memory map, region depths, I/O register indices and vector typedefs

package mem_pkg;

    // Vectors with a fixed meaning on the bus
    typedef logic [31:0] word_t;
    typedef logic [31:0] bus_addr_t;
    typedef logic [3:0]  byte_en_t;
    typedef logic [1:0]  access_size_t;
    typedef logic [15:0] half_t;

    // Access size codes presented on bus_size
    localparam access_size_t SIZE_BYTE = 2'd0;
    localparam access_size_t SIZE_HALF = 2'd1;
    localparam access_size_t SIZE_WORD = 2'd2;

    // Region start addresses
    localparam bus_addr_t INTERN_RAM_START = 32'h0300_0000;
    localparam bus_addr_t IO_REG_START     = 32'h0400_0000;
    localparam bus_addr_t PALETTE_START    = 32'h0500_0000;
    localparam bus_addr_t VRAM_START       = 32'h0600_0000;

    // Region depths in 32-bit words
    localparam int INTERN_RAM_WORDS = 1024;
    localparam int PALETTE_WORDS    = 128;
    localparam int VRAM_WORDS       = 2048;

    // Word index widths for each region
    localparam int INTERN_IDX_W  = $clog2(INTERN_RAM_WORDS);
    localparam int PALETTE_IDX_W = $clog2(PALETTE_WORDS);
    localparam int VRAM_IDX_W    = $clog2(VRAM_WORDS);

    // I/O register block
    localparam int NUM_IO_REGS  = 8;
    localparam int IO_IDX_W     = $clog2(NUM_IO_REGS);
    localparam int KEYINPUT_IDX = 4;
    localparam int IRQ_IDX      = 6;

endpackage : mem_pkg

//--- src/bus_write_stage.sv
// Bus request latch and write pause
// Produces the memory address and little-endian byte-lane enables

`timescale 1ns/100ps

module bus_write_stage (
    input  logic                  clock,
    input  logic                  reset,
    input  mem_pkg::bus_addr_t    bus_addr,
    input  mem_pkg::access_size_t bus_size,
    input  logic                  bus_write,
    output logic                  bus_pause,
    output mem_pkg::bus_addr_t    addr_lat,
    output logic                  write_lat,
    output mem_pkg::bus_addr_t    mem_addr,
    output mem_pkg::byte_en_t     byte_en
);

    mem_pkg::access_size_t size_lat;
    logic                  write_active;

    // Address and size of the previous cycle
    always_ff @(posedge clock) begin
        addr_lat <= bus_addr;
        size_lat <= bus_size;
    end

    // A write seen with the pause low holds the master for one cycle
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            write_lat <= 1'b0;
            bus_pause <= 1'b0;
        end else begin
            write_lat <= bus_write;
            bus_pause <= bus_write & ~bus_pause;
        end
    end

    // The held write is latched again after the pause, so only the
    // pause cycle commits it
    assign write_active = write_lat & bus_pause;

    assign mem_addr = write_active ? addr_lat : bus_addr;

    always_comb begin
        byte_en = '0;
        if (write_active) begin
            case (size_lat)
                mem_pkg::SIZE_BYTE: byte_en[addr_lat[1:0]] = 1'b1;
                mem_pkg::SIZE_HALF: byte_en = addr_lat[1] ? 4'b1100 : 4'b0011;
                mem_pkg::SIZE_WORD: byte_en = 4'b1111;
                default:            byte_en = '0;
            endcase
        end
    end

endmodule : bus_write_stage

//--- src/bus_region_map.sv
// Address decode for work RAM, VRAM, palette RAM and I/O registers
// Region-local word indices, per-region write enables, read data select

`timescale 1ns/100ps

module bus_region_map (
    input  mem_pkg::bus_addr_t                mem_addr,
    input  mem_pkg::bus_addr_t                addr_lat,
    input  mem_pkg::byte_en_t                 byte_en,
    input  mem_pkg::word_t                    intern_rdata,
    input  mem_pkg::word_t                    vram_rdata,
    input  mem_pkg::word_t                    palette_rdata,
    input  mem_pkg::word_t                    io_rdata,
    output logic [mem_pkg::INTERN_IDX_W-1:0]  intern_index,
    output logic [mem_pkg::VRAM_IDX_W-1:0]    vram_index,
    output logic [mem_pkg::PALETTE_IDX_W-1:0] palette_index,
    output mem_pkg::byte_en_t                 intern_we,
    output mem_pkg::byte_en_t                 vram_we,
    output mem_pkg::byte_en_t                 palette_we,
    output mem_pkg::byte_en_t                 io_we,
    output logic [mem_pkg::IO_IDX_W-1:0]      io_index,
    output mem_pkg::word_t                    bus_rdata
);

    // Byte offsets into each RAM for the address going to the memories
    mem_pkg::bus_addr_t intern_off;
    mem_pkg::bus_addr_t vram_off;
    mem_pkg::bus_addr_t palette_off;

    // Byte offsets of the latched address, which owns the read data
    mem_pkg::bus_addr_t intern_lat_off;
    mem_pkg::bus_addr_t vram_lat_off;
    mem_pkg::bus_addr_t palette_lat_off;
    mem_pkg::bus_addr_t io_lat_off;

    logic intern_hit;
    logic vram_hit;
    logic palette_hit;
    logic intern_sel;
    logic vram_sel;
    logic palette_sel;
    logic io_sel;

    assign intern_off  = mem_addr - mem_pkg::INTERN_RAM_START;
    assign vram_off    = mem_addr - mem_pkg::VRAM_START;
    assign palette_off = mem_addr - mem_pkg::PALETTE_START;

    // Addresses below a region start wrap to large offsets and miss
    assign intern_hit  = intern_off[31:2] < mem_pkg::INTERN_RAM_WORDS;
    assign vram_hit    = vram_off[31:2] < mem_pkg::VRAM_WORDS;
    assign palette_hit = palette_off[31:2] < mem_pkg::PALETTE_WORDS;

    assign intern_index  = intern_off[2 +: mem_pkg::INTERN_IDX_W];
    assign vram_index    = vram_off[2 +: mem_pkg::VRAM_IDX_W];
    assign palette_index = palette_off[2 +: mem_pkg::PALETTE_IDX_W];

    assign intern_we  = intern_hit ? byte_en : '0;
    assign vram_we    = vram_hit ? byte_en : '0;
    assign palette_we = palette_hit ? byte_en : '0;

    assign intern_lat_off  = addr_lat - mem_pkg::INTERN_RAM_START;
    assign vram_lat_off    = addr_lat - mem_pkg::VRAM_START;
    assign palette_lat_off = addr_lat - mem_pkg::PALETTE_START;
    assign io_lat_off      = addr_lat - mem_pkg::IO_REG_START;

    assign intern_sel  = intern_lat_off[31:2] < mem_pkg::INTERN_RAM_WORDS;
    assign vram_sel    = vram_lat_off[31:2] < mem_pkg::VRAM_WORDS;
    assign palette_sel = palette_lat_off[31:2] < mem_pkg::PALETTE_WORDS;
    assign io_sel      = io_lat_off[31:2] < mem_pkg::NUM_IO_REGS;

    // I/O reads are combinational, so the register block works off the
    // latched address; byte_en is only set when mem_addr equals it
    assign io_index = io_lat_off[2 +: mem_pkg::IO_IDX_W];
    assign io_we    = io_sel ? byte_en : '0;

    always_comb begin
        if (intern_sel) begin
            bus_rdata = intern_rdata;
        end else if (vram_sel) begin
            bus_rdata = vram_rdata;
        end else if (palette_sel) begin
            bus_rdata = palette_rdata;
        end else if (io_sel) begin
            bus_rdata = io_rdata;
        end else begin
            bus_rdata = '0;
        end
    end

endmodule : bus_region_map

//--- src/dual_port_ram.sv
// Byte-writable dual-port memory
// Read-write bus port in write-first mode, read-only graphics port

`timescale 1ns/100ps

module dual_port_ram #(
    parameter  int DEPTH   = 1024,
    localparam int INDEX_W = $clog2(DEPTH)
) (
    input  logic               clock,
    input  logic [INDEX_W-1:0] a_index,
    input  mem_pkg::byte_en_t  a_we,
    input  mem_pkg::word_t     a_wdata,
    output mem_pkg::word_t     a_rdata,
    input  logic [INDEX_W-1:0] b_index,
    output mem_pkg::word_t     b_rdata
);

    mem_pkg::word_t mem [DEPTH];
    mem_pkg::word_t a_word_next;

    // Stored word with the enabled lanes replaced
    always_comb begin
        a_word_next = mem[a_index];
        for (int lane = 0; lane < 4; lane++) begin
            if (a_we[lane]) begin
                a_word_next[8*lane +: 8] = a_wdata[8*lane +: 8];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (|a_we) begin
            mem[a_index] <= a_word_next;
        end
        a_rdata <= a_word_next;
    end

    // Graphics port sees a same-cycle write one cycle later
    always_ff @(posedge clock) begin
        b_rdata <= mem[b_index];
    end

endmodule : dual_port_ram

//--- src/io_register_file.sv
// Memory-mapped I/O register block
// Byte-writable words, key-input word, interrupt enable and acknowledge

`timescale 1ns/100ps

module io_register_file (
    input  logic                         clock,
    input  logic                         reset,
    input  logic [mem_pkg::IO_IDX_W-1:0] io_index,
    input  mem_pkg::byte_en_t            io_we,
    input  mem_pkg::word_t               bus_wdata,
    input  mem_pkg::half_t               buttons,
    input  mem_pkg::half_t               reg_if,
    output mem_pkg::word_t               io_rdata,
    output mem_pkg::word_t               io_reg_data [mem_pkg::NUM_IO_REGS],
    output mem_pkg::half_t               int_acks
);

    // Replace the bytes of a half word selected by we
    function automatic mem_pkg::half_t merge_half(
        input mem_pkg::half_t old_value,
        input mem_pkg::half_t new_value,
        input logic [1:0]     we
    );
        mem_pkg::half_t result;
        result = old_value;
        if (we[0]) begin
            result[7:0] = new_value[7:0];
        end
        if (we[1]) begin
            result[15:8] = new_value[15:8];
        end
        return result;
    endfunction

    mem_pkg::byte_en_t reg_we [mem_pkg::NUM_IO_REGS];

    for (genvar i = 0; i < mem_pkg::NUM_IO_REGS; i++) begin : g_reg
        assign reg_we[i] = (io_index == mem_pkg::IO_IDX_W'(i)) ? io_we : '0;

        if (i == mem_pkg::KEYINPUT_IDX) begin : g_key
            // Low half follows the buttons, upper half is storage
            mem_pkg::half_t key_high;

            always_ff @(posedge clock or posedge reset) begin
                if (reset) begin
                    key_high <= '0;
                end else begin
                    key_high <= merge_half(key_high, bus_wdata[31:16], reg_we[i][3:2]);
                end
            end

            assign io_reg_data[i] = {key_high, buttons};
        end else if (i == mem_pkg::IRQ_IDX) begin : g_irq
            mem_pkg::half_t int_enable;

            always_ff @(posedge clock or posedge reset) begin
                if (reset) begin
                    int_enable <= '0;
                    int_acks   <= '0;
                end else begin
                    int_enable <= merge_half(int_enable, bus_wdata[15:0], reg_we[i][1:0]);
                    // Acknowledge bits last one cycle then drop
                    int_acks   <= merge_half('0, bus_wdata[31:16], reg_we[i][3:2]);
                end
            end

            // Upper half reads the pending flags instead of the acks
            assign io_reg_data[i] = {reg_if, int_enable};
        end else begin : g_plain
            mem_pkg::word_t value;

            always_ff @(posedge clock or posedge reset) begin
                if (reset) begin
                    value <= '0;
                end else begin
                    value[31:16] <= merge_half(value[31:16], bus_wdata[31:16],
                                               reg_we[i][3:2]);
                    value[15:0]  <= merge_half(value[15:0], bus_wdata[15:0],
                                               reg_we[i][1:0]);
                end
            end

            assign io_reg_data[i] = value;
        end
    end

    assign io_rdata = io_reg_data[io_index];

endmodule : io_register_file

//--- src/mem_top.sv
// Memory controller top level
// Write stage, region map, work RAM, VRAM, palette RAM and I/O registers

`timescale 1ns/100ps

module mem_top (
    input  logic                  clock,
    input  logic                  reset,

    // CPU/DMA bus
    input  mem_pkg::bus_addr_t    bus_addr,
    input  mem_pkg::word_t        bus_wdata,
    input  mem_pkg::access_size_t bus_size,
    input  logic                  bus_write,
    output mem_pkg::word_t        bus_rdata,
    output logic                  bus_pause,

    // Graphics read ports
    input  mem_pkg::bus_addr_t    gfx_vram_addr,
    input  mem_pkg::bus_addr_t    gfx_palette_addr,
    output mem_pkg::word_t        gfx_vram_data,
    output mem_pkg::word_t        gfx_palette_data,

    // I/O register exports and read-only sources
    input  mem_pkg::half_t        buttons,
    input  mem_pkg::half_t        reg_if,
    output mem_pkg::word_t        io_reg_data [mem_pkg::NUM_IO_REGS],
    output mem_pkg::half_t        int_acks
);

    mem_pkg::bus_addr_t addr_lat;
    mem_pkg::bus_addr_t mem_addr;
    mem_pkg::byte_en_t  byte_en;

    logic [mem_pkg::INTERN_IDX_W-1:0]  intern_index;
    logic [mem_pkg::VRAM_IDX_W-1:0]    vram_index;
    logic [mem_pkg::PALETTE_IDX_W-1:0] palette_index;
    logic [mem_pkg::IO_IDX_W-1:0]      io_index;

    mem_pkg::byte_en_t intern_we;
    mem_pkg::byte_en_t vram_we;
    mem_pkg::byte_en_t palette_we;
    mem_pkg::byte_en_t io_we;

    mem_pkg::word_t intern_rdata;
    mem_pkg::word_t vram_rdata;
    mem_pkg::word_t palette_rdata;
    mem_pkg::word_t io_rdata;

    bus_write_stage u_write_stage (
        .clock     (clock),
        .reset     (reset),
        .bus_addr  (bus_addr),
        .bus_size  (bus_size),
        .bus_write (bus_write),
        .bus_pause (bus_pause),
        .addr_lat  (addr_lat),
        .write_lat (),
        .mem_addr  (mem_addr),
        .byte_en   (byte_en)
    );

    bus_region_map u_region_map (
        .mem_addr      (mem_addr),
        .addr_lat      (addr_lat),
        .byte_en       (byte_en),
        .intern_rdata  (intern_rdata),
        .vram_rdata    (vram_rdata),
        .palette_rdata (palette_rdata),
        .io_rdata      (io_rdata),
        .intern_index  (intern_index),
        .vram_index    (vram_index),
        .palette_index (palette_index),
        .intern_we     (intern_we),
        .vram_we       (vram_we),
        .palette_we    (palette_we),
        .io_we         (io_we),
        .io_index      (io_index),
        .bus_rdata     (bus_rdata)
    );

    // Work RAM has no graphics client
    dual_port_ram #(.DEPTH(mem_pkg::INTERN_RAM_WORDS)) intern_ram (
        .clock   (clock),
        .a_index (intern_index),
        .a_we    (intern_we),
        .a_wdata (bus_wdata),
        .a_rdata (intern_rdata),
        .b_index ('0),
        .b_rdata ()
    );

    // Graphics addresses are byte addresses, only the word bits index the RAM
    dual_port_ram #(.DEPTH(mem_pkg::VRAM_WORDS)) vram (
        .clock   (clock),
        .a_index (vram_index),
        .a_we    (vram_we),
        .a_wdata (bus_wdata),
        .a_rdata (vram_rdata),
        .b_index (gfx_vram_addr[2 +: mem_pkg::VRAM_IDX_W]),
        .b_rdata (gfx_vram_data)
    );

    dual_port_ram #(.DEPTH(mem_pkg::PALETTE_WORDS)) palette_ram (
        .clock   (clock),
        .a_index (palette_index),
        .a_we    (palette_we),
        .a_wdata (bus_wdata),
        .a_rdata (palette_rdata),
        .b_index (gfx_palette_addr[2 +: mem_pkg::PALETTE_IDX_W]),
        .b_rdata (gfx_palette_data)
    );

    io_register_file u_io_regs (
        .clock       (clock),
        .reset       (reset),
        .io_index    (io_index),
        .io_we       (io_we),
        .bus_wdata   (bus_wdata),
        .buttons     (buttons),
        .reg_if      (reg_if),
        .io_rdata    (io_rdata),
        .io_reg_data (io_reg_data),
        .int_acks    (int_acks)
    );

endmodule : mem_top

//--- bench/tb_clock_gen.sv
// Testbench clock and reset source
// 40 ns clock, active high reset held for a fixed number of cycles

`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int HALF_PERIOD  = 20,
    parameter int RESET_CYCLES = 10
) (
    output logic clock,
    output logic reset
);

    initial begin
        clock = 1'b0;
        forever #(HALF_PERIOD) clock = ~clock;
    end

    // Release on a falling edge, away from the sampling edge
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
    end

endmodule : tb_clock_gen

//--- bench/mem_top_assert.sv
// Concurrent checks on the write stage pause and byte-lane enables
// Bound into every bus_write_stage instance

`timescale 1ns/100ps

module mem_top_assert (
    input logic              clock,
    input logic              reset,
    input logic              bus_write,
    input logic              bus_pause,
    input logic              write_lat,
    input mem_pkg::byte_en_t byte_en
);

    // Number of failed assertion attempts
    int failures = 0;

    // Pause never lasts past one cycle
    pause_one_cycle: assert property (@(posedge clock) disable iff (reset)
        bus_pause |=> !bus_pause)
        else begin
            $error("bus_pause held for more than one cycle");
            failures++;
        end

    pause_after_write: assert property (@(posedge clock) disable iff (reset)
        (bus_write && !bus_pause) |=> bus_pause)
        else begin
            $error("write presented with pause low did not raise bus_pause");
            failures++;
        end

    // Lanes only open while a write is latched
    idle_lanes_closed: assert property (@(posedge clock) disable iff (reset)
        !write_lat |-> (byte_en == '0))
        else begin
            $error("byte_en active with no latched write");
            failures++;
        end

endmodule : mem_top_assert

bind bus_write_stage mem_top_assert u_write_assert (
    .clock     (clock),
    .reset     (reset),
    .bus_write (bus_write),
    .bus_pause (bus_pause),
    .write_lat (write_lat),
    .byte_en   (byte_en)
);

//--- bench/mem_top_tb.sv
// Testbench for the memory controller
// Replays directed vectors, checks read data, pause, graphics ports and acks

`timescale 1ns/100ps

module mem_top_tb;

    localparam int MAX_VECTORS    = 64;
    localparam int TIMEOUT_CYCLES = 20;

    // Operation codes of the vector file
    localparam int OP_END      = 0;
    localparam int OP_WRITE    = 1;
    localparam int OP_READ     = 2;
    localparam int OP_MODEL    = 3;
    localparam int OP_FILL     = 4;
    localparam int OP_GFX_VRAM = 5;
    localparam int OP_GFX_PAL  = 6;
    localparam int OP_INPUTS   = 7;

    logic                  clock;
    logic                  reset;
    mem_pkg::bus_addr_t    bus_addr;
    mem_pkg::word_t        bus_wdata;
    mem_pkg::access_size_t bus_size;
    logic                  bus_write;
    mem_pkg::word_t        bus_rdata;
    logic                  bus_pause;
    mem_pkg::bus_addr_t    gfx_vram_addr;
    mem_pkg::bus_addr_t    gfx_palette_addr;
    mem_pkg::word_t        gfx_vram_data;
    mem_pkg::word_t        gfx_palette_data;
    mem_pkg::half_t        buttons;
    mem_pkg::half_t        reg_if;
    mem_pkg::word_t        io_reg_data [mem_pkg::NUM_IO_REGS];
    mem_pkg::half_t        int_acks;

    logic [31:0]    vectors [5*MAX_VECTORS];
    mem_pkg::word_t model [mem_pkg::bus_addr_t];
    int             errors;
    int             tests_run;
    int             tests_failed;
    logic           timed_out;

    tb_clock_gen u_clock_gen (
        .clock (clock),
        .reset (reset)
    );

    mem_top DUT (
        .clock            (clock),
        .reset            (reset),
        .bus_addr         (bus_addr),
        .bus_wdata        (bus_wdata),
        .bus_size         (bus_size),
        .bus_write        (bus_write),
        .bus_rdata        (bus_rdata),
        .bus_pause        (bus_pause),
        .gfx_vram_addr    (gfx_vram_addr),
        .gfx_palette_addr (gfx_palette_addr),
        .gfx_vram_data    (gfx_vram_data),
        .gfx_palette_data (gfx_palette_data),
        .buttons          (buttons),
        .reg_if           (reg_if),
        .io_reg_data      (io_reg_data),
        .int_acks         (int_acks)
    );

    // Byte write picks one little-endian lane and half write picks a lane pair
    function automatic mem_pkg::word_t merge_lanes(
        input mem_pkg::word_t        old_word,
        input mem_pkg::word_t        data,
        input mem_pkg::access_size_t size,
        input logic [1:0]            offset
    );
        mem_pkg::word_t result;
        logic           selected;
        result = old_word;
        for (int lane = 0; lane < 4; lane++) begin
            case (size)
                mem_pkg::SIZE_BYTE: selected = (lane == offset);
                mem_pkg::SIZE_HALF: selected = ((lane / 2) == offset[1]);
                default:            selected = 1'b1;
            endcase
            if (selected) begin
                result[8*lane +: 8] = data[8*lane +: 8];
            end
        end
        return result;
    endfunction

    function automatic mem_pkg::word_t model_word(input mem_pkg::bus_addr_t addr);
        mem_pkg::bus_addr_t key;
        key = {addr[31:2], 2'b00};
        return model.exists(key) ? model[key] : '0;
    endfunction

    task automatic check_value(input string what, input mem_pkg::word_t actual,
                               input mem_pkg::word_t expected);
        assert (actual === expected) else begin
            $display("Fail at time %0t: %s is %h, expected %h", $time, what, actual, expected);
            errors++;
        end
    endtask

    // Counts falling edges until bus_pause reaches the wanted level
    task automatic wait_pause(input logic level, output int cycles);
        cycles = 0;
        do begin
            @(negedge clock);
            cycles++;
        end while (bus_pause !== level && cycles < TIMEOUT_CYCLES);
        if (bus_pause !== level) begin
            $display("Timeout: bus_pause did not go %0b within %0d cycles", level, cycles);
            timed_out = 1'b1;
        end
    endtask

    task automatic write_word(input mem_pkg::bus_addr_t addr, input mem_pkg::access_size_t size,
                              input mem_pkg::word_t data, input mem_pkg::half_t acks_expected);
        int cycles;
        bus_addr  = addr;
        bus_size  = size;
        bus_wdata = data;
        bus_write = 1'b1;
        wait_pause(1'b1, cycles);
        if (!timed_out) begin
            check_value("cycles before pause", cycles, 1);
            wait_pause(1'b0, cycles);
        end
        if (!timed_out) begin
            check_value("pause length", cycles, 1);
            check_value("int_acks pulse", {16'h0, int_acks}, {16'h0, acks_expected});
            bus_write = 1'b0;
            @(negedge clock);
            check_value("int_acks after pulse", {16'h0, int_acks}, '0);
            model[{addr[31:2], 2'b00}] = merge_lanes(model_word(addr), data, size, addr[1:0]);
        end
        bus_write = 1'b0;
    endtask

    task automatic read_word(input mem_pkg::bus_addr_t addr, output mem_pkg::word_t data);
        bus_addr  = addr;
        bus_write = 1'b0;
        @(negedge clock);
        assert (bus_pause === 1'b0) else begin
            $display("Fail at time %0t: bus_pause rose during a read of %h", $time, addr);
            errors++;
        end
        data = bus_rdata;
    endtask

    initial begin
        mem_pkg::bus_addr_t    addr;
        mem_pkg::access_size_t size;
        mem_pkg::word_t        data;
        mem_pkg::word_t        expected;
        mem_pkg::word_t        actual;
        int                    op;
        int                    errors_before;
        int                    cycles;
        int                    vector_count;
        int                    assert_failures;

        errors           = 0;
        tests_run        = 0;
        tests_failed     = 0;
        vector_count     = 0;
        timed_out        = 1'b0;
        bus_addr         = '0;
        bus_wdata        = '0;
        bus_size         = mem_pkg::SIZE_WORD;
        bus_write        = 1'b0;
        gfx_vram_addr    = '0;
        gfx_palette_addr = '0;
        buttons          = '0;
        reg_if           = '0;
        void'($urandom(42));
        $readmemh("bench/mem_vectors.txt", vectors);

        cycles = 0;
        do begin
            @(negedge clock);
            cycles++;
        end while (reset !== 1'b0 && cycles < 3 * TIMEOUT_CYCLES);
        if (reset !== 1'b0) begin
            $display("Timeout: reset was never released");
            timed_out = 1'b1;
        end else begin
            errors_before = errors;
            check_value("bus_pause after reset", {31'h0, bus_pause}, '0);
            check_value("int_acks after reset", {16'h0, int_acks}, '0);
            tests_run++;
            tests_failed += (errors != errors_before);
            $display("Reset state: %s", (errors == errors_before) ? "ok" : "failed");
        end

        for (int v = 0; v < MAX_VECTORS && !timed_out; v++) begin
            op = vectors[5*v];
            if (op == OP_END) begin
                break;
            end
            addr          = vectors[5*v + 1];
            size          = vectors[5*v + 2][1:0];
            data          = vectors[5*v + 3];
            expected      = vectors[5*v + 4];
            errors_before = errors;
            vector_count++;
            case (op)
                OP_WRITE: write_word(addr, size, data, expected[15:0]);
                OP_FILL:  write_word(addr, mem_pkg::SIZE_WORD, $urandom(), '0);
                OP_READ: begin
                    read_word(addr, actual);
                    check_value("bus_rdata", actual, expected);
                    if (addr >= mem_pkg::IO_REG_START &&
                        addr < mem_pkg::IO_REG_START + 4 * mem_pkg::NUM_IO_REGS) begin
                        check_value("io_reg_data",
                                    io_reg_data[(addr - mem_pkg::IO_REG_START) >> 2], expected);
                    end
                end
                OP_MODEL: begin
                    read_word(addr, actual);
                    check_value("merged word", actual, model_word(addr));
                end
                OP_GFX_VRAM: begin
                    gfx_vram_addr = addr;
                    @(negedge clock);
                    check_value("gfx_vram_data", gfx_vram_data, expected);
                end
                OP_GFX_PAL: begin
                    gfx_palette_addr = addr;
                    @(negedge clock);
                    check_value("gfx_palette_data", gfx_palette_data, expected);
                end
                OP_INPUTS: begin
                    buttons = data[15:0];
                    reg_if  = data[31:16];
                end
                default: begin
                    $display("Vector %0d has an unknown operation code %0d", v, op);
                    errors++;
                end
            endcase
            tests_run++;
            tests_failed += (errors != errors_before || timed_out);
            $display("Vector %0d op %0d at %h: %s", v, op, addr,
                     (errors == errors_before && !timed_out) ? "ok" : "failed");
        end

        if (vector_count == 0 && !timed_out) begin
            $display("No vectors were loaded from bench/mem_vectors.txt");
            errors++;
        end
        assert_failures = DUT.u_write_stage.u_write_assert.failures;
        $display("Tests run %0d, passed %0d, failed %0d, check errors %0d, assert errors %0d",
                 tests_run, tests_run - tests_failed, tests_failed, errors, assert_failures);
        if (errors == 0 && assert_failures == 0 && !timed_out) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule : mem_top_tb

//--- bench/mem_vectors.txt
// Columns (hex): op addr size data expected. Ops: 1 write (expected = int_acks pulse),
// 2 read, 3 read against lane model, 4 random fill, 5 gfx vram, 6 gfx palette, 7 inputs
1 03000010 2 cafef00d 00000000
2 03000010 0 00000000 cafef00d
1 06000100 2 12345678 00000000
2 06000100 0 00000000 12345678
5 06000100 0 00000000 12345678
1 05000040 2 a5a5c3c3 00000000
2 05000040 0 00000000 a5a5c3c3
6 05000040 0 00000000 a5a5c3c3
2 08000000 0 00000000 00000000
4 03000020 2 00000000 00000000
1 03000021 0 44332211 00000000
1 03000022 1 88776655 00000000
3 03000020 0 00000000 00000000
4 06000200 2 00000000 00000000
1 06000203 0 ddccbbaa 00000000
3 06000200 0 00000000 00000000
1 04000004 2 deadbeef 00000000
2 04000004 0 00000000 deadbeef
7 00000000 0 00a51234 00000000
1 04000010 2 ffffffff 00000000
2 04000010 0 00000000 ffff1234
1 04000018 2 000300f0 00000003
1 0400001a 1 00050000 00000005
2 04000018 0 00000000 00a500f0
2 04000020 0 00000000 00000000
0 00000000 0 00000000 00000000

//--- tb.f
src/mem_pkg.sv
src/bus_write_stage.sv
src/bus_region_map.sv
src/dual_port_ram.sv
src/io_register_file.sv
src/mem_top.sv
bench/tb_clock_gen.sv
bench/mem_top_assert.sv
bench/mem_top_tb.sv
